/* common/dmem_wb_macros.svh */
// Bus width, byte lane, byte offset and request queue depth macros for the dmem Wishbone bridge
`ifndef DMEM_WB_MACROS_SVH
`define DMEM_WB_MACROS_SVH

// ---------------------------------------------------------------------------
// Bus geometry
// ---------------------------------------------------------------------------

// Data and address width of the Wishbone port
`define DMEM_WB_WIDTH 32

// Byte lanes on the data bus
`define DMEM_WB_SEL_WIDTH 4

// Address bits that pick a byte inside one word
`define DMEM_WB_OFFS_WIDTH 2

// ---------------------------------------------------------------------------
// Request path
// ---------------------------------------------------------------------------

// Entries in the request queue
`define DMEM_REQ_FIFO_DEPTH 2

`endif

/* common/dmem_wb_pkg.sv */
// Command, width and response enumerations, bus word and select types, queued request struct
`default_nettype none

`include "dmem_wb_macros.svh"

package dmem_wb_pkg;

    // ------------------------------------------------------------------------
    // Core side encodings
    // ------------------------------------------------------------------------

    // Direction of a core request
    typedef enum logic {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    // Access size of a core request
    // Code 2'b11 is unused and treated as a word
    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'b00,
        MEM_WIDTH_HWORD = 2'b01,
        MEM_WIDTH_WORD  = 2'b10
    } mem_width_e;

    // Response reported back to the core
    typedef enum logic [1:0] {
        MEM_RESP_NOTRDY = 2'b00,
        MEM_RESP_RDY_OK = 2'b01,
        MEM_RESP_RDY_ER = 2'b10
    } mem_resp_e;

    // ------------------------------------------------------------------------
    // Bus side types
    // ------------------------------------------------------------------------

    // One data or address word
    typedef logic [`DMEM_WB_WIDTH-1:0] wb_word_t;

    // One select bit per byte lane
    typedef logic [`DMEM_WB_SEL_WIDTH-1:0] wb_sel_t;

    // Queued request, already in bus form
    typedef struct packed {
        // High for a write
        logic       we;
        // Access size, kept for the read alignment
        mem_width_e width;
        // Full byte address
        wb_word_t   addr;
        // Write data on its lanes
        wb_word_t   wdata;
        // Active byte lanes
        wb_sel_t    sel;
    } dmem_req_s;

endpackage

`default_nettype wire

/* hw/req_path/dmem_req_pack.sv */
// Request packer: write lane steering, byte select generation and write flag for one core request
`timescale 1ns/10ps
`default_nettype none

`include "dmem_wb_macros.svh"

module dmem_req_pack
    import dmem_wb_pkg::*;
(
    input  mem_cmd_e   cmd_i,
    input  mem_width_e width_i,
    input  wb_word_t   addr_i,
    input  wb_word_t   wdata_i,
    output dmem_req_s  entry_o
);

    // Byte position inside the addressed word
    logic [`DMEM_WB_OFFS_WIDTH-1:0] offs;
    // Bit position of the addressed byte
    logic [`DMEM_WB_OFFS_WIDTH+2:0] bit_offs;
    wb_word_t                       lane_data;
    wb_sel_t                        lane_sel;

    assign offs     = addr_i[`DMEM_WB_OFFS_WIDTH-1:0];
    assign bit_offs = {offs, 3'b000};

    // ------------------------------------------------------------------------
    // Lane steering
    // ------------------------------------------------------------------------

    always_comb begin
        case (width_i)
            MEM_WIDTH_BYTE: begin
                // Low byte moved up to its lane
                lane_data = wb_word_t'(wdata_i[7:0]) << bit_offs;
                lane_sel  = wb_sel_t'(1) << offs;
            end
            MEM_WIDTH_HWORD: begin
                // Offset bit 1 picks the upper or lower half
                if (offs[1]) begin
                    lane_data = {wdata_i[15:0], 16'h0000};
                    lane_sel  = 4'b1100;
                end else begin
                    lane_data = {16'h0000, wdata_i[15:0]};
                    lane_sel  = 4'b0011;
                end
            end
            default: begin
                // Word, and the unused code
                lane_data = wdata_i;
                lane_sel  = '1;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Queue entry
    // ------------------------------------------------------------------------

    assign entry_o.we    = (cmd_i == MEM_CMD_WR);
    assign entry_o.width = width_i;
    // Address goes out unchanged, lanes carry the offset
    assign entry_o.addr  = addr_i;
    assign entry_o.wdata = lane_data;
    assign entry_o.sel   = lane_sel;

endmodule

`default_nettype wire

/* hw/req_path/dmem_req_fifo.sv */
// Request queue: circular buffer with read and write pointers, occupancy count, empty and full flags
`timescale 1ns/10ps
`default_nettype none

`include "dmem_wb_macros.svh"

module dmem_req_fifo
    import dmem_wb_pkg::*;
#(
    parameter int DEPTH = `DMEM_REQ_FIFO_DEPTH
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic push_i,
    input  dmem_req_s entry_i,
    input  wire logic pop_i,
    output dmem_req_s head_o,
    output logic      empty_o,
    output logic      full_o
);

    // Pointer keeps at least one bit for a single entry queue
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    // Count has to reach DEPTH itself
    localparam int CNT_W = $clog2(DEPTH + 1);

    dmem_req_s        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Step a pointer, wrapping at the last slot
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // ------------------------------------------------------------------------
    // Flags and qualified handshakes
    // ------------------------------------------------------------------------

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(DEPTH));

    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    // ------------------------------------------------------------------------
    // Pointers and count
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // Push and pop together leave the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= entry_i;
        end
    end

    // Oldest entry, valid while not empty
    assign head_o = mem[rd_ptr];

endmodule

`default_nettype wire

/* hw/dmem_resp_align.sv */
// Response stage: registers the Wishbone completion, aligns read data and encodes the core response
`timescale 1ns/10ps
`default_nettype none

`include "dmem_wb_macros.svh"

module dmem_resp_align
    import dmem_wb_pkg::*;
(
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic                           ack_i,
    input  wire logic                           err_i,
    input  wb_word_t                            rdata_i,
    input  mem_width_e                          head_width_i,
    input  wire logic [`DMEM_WB_OFFS_WIDTH-1:0] head_offs_i,
    output wb_word_t                            rdata_o,
    output mem_resp_e                           resp_o
);

    // Completion seen on the previous edge
    logic                           valid_q;
    logic                           err_q;
    wb_word_t                       rdata_q;
    // Size and position of the retired request
    mem_width_e                     width_q;
    logic [`DMEM_WB_OFFS_WIDTH-1:0] offs_q;
    wb_word_t                       shifted;

    // ------------------------------------------------------------------------
    // Completion capture
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            // One cycle pulse per acknowledge
            valid_q <= ack_i;
        end
    end

    always_ff @(posedge clk) begin
        if (ack_i) begin
            err_q   <= err_i;
            rdata_q <= rdata_i;
            width_q <= head_width_i;
            offs_q  <= head_offs_i;
        end
    end

    // ------------------------------------------------------------------------
    // Read alignment
    // ------------------------------------------------------------------------

    // Addressed byte lane moved down to bit 0
    assign shifted = rdata_q >> {offs_q, 3'b000};

    always_comb begin
        case (width_q)
            MEM_WIDTH_BYTE:  rdata_o = {{(`DMEM_WB_WIDTH-8){1'b0}}, shifted[7:0]};
            MEM_WIDTH_HWORD: begin
                // Halfwords sit on offset 0 or 2
                if (offs_q[1]) begin
                    rdata_o = {{(`DMEM_WB_WIDTH-16){1'b0}}, rdata_q[31:16]};
                end else begin
                    rdata_o = {{(`DMEM_WB_WIDTH-16){1'b0}}, rdata_q[15:0]};
                end
            end
            default:         rdata_o = rdata_q;
        endcase
    end

    // Response code
    always_comb begin
        if (!valid_q) begin
            resp_o = MEM_RESP_NOTRDY;
        end else if (err_q) begin
            resp_o = MEM_RESP_RDY_ER;
        end else begin
            resp_o = MEM_RESP_RDY_OK;
        end
    end

endmodule

`default_nettype wire

/* hw/dmem_wb_bridge.sv */
// Top level of the data memory to Wishbone bridge: request packing, request queue, response stage
`timescale 1ns/10ps
`default_nettype none

`include "dmem_wb_macros.svh"

module dmem_wb_bridge
    import dmem_wb_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,

    // Core request side
    input  wire logic       dmem_req_i,
    input  mem_cmd_e        dmem_cmd_i,
    input  mem_width_e      dmem_width_i,
    input  wb_word_t        dmem_addr_i,
    input  wb_word_t        dmem_wdata_i,
    output logic            dmem_req_ack_o,

    // Core response side
    output wb_word_t        dmem_rdata_o,
    output mem_resp_e       dmem_resp_o,

    // Wishbone master port
    output logic            wbd_stb_o,
    output wb_word_t        wbd_adr_o,
    output logic            wbd_we_o,
    output wb_word_t        wbd_dat_o,
    output wb_sel_t         wbd_sel_o,
    input  wb_word_t        wbd_dat_i,
    input  wire logic       wbd_ack_i,
    input  wire logic       wbd_err_i
);

    // Entry built from the current core inputs
    dmem_req_s new_entry;
    // Oldest queued request, driving the bus
    dmem_req_s head;
    logic      fifo_empty;
    logic      fifo_full;

    // ------------------------------------------------------------------------
    // Request path
    // ------------------------------------------------------------------------

    dmem_req_pack i_req_pack (
        .cmd_i   (dmem_cmd_i),
        .width_i (dmem_width_i),
        .addr_i  (dmem_addr_i),
        .wdata_i (dmem_wdata_i),
        .entry_o (new_entry)
    );

    // Push and pop are qualified inside the queue
    dmem_req_fifo #(
        .DEPTH (`DMEM_REQ_FIFO_DEPTH)
    ) i_req_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (dmem_req_i),
        .entry_i (new_entry),
        .pop_i   (wbd_ack_i),
        .head_o  (head),
        .empty_o (fifo_empty),
        .full_o  (fifo_full)
    );

    // Core may hand over a request whenever there is room
    assign dmem_req_ack_o = ~fifo_full;

    // Head entry straight onto the bus
    assign wbd_stb_o = ~fifo_empty;
    assign wbd_adr_o = head.addr;
    assign wbd_we_o  = head.we;
    assign wbd_dat_o = head.wdata;
    assign wbd_sel_o = head.sel;

    // ------------------------------------------------------------------------
    // Response path
    // ------------------------------------------------------------------------

    dmem_resp_align i_resp_align (
        .clk          (clk),
        .rst_n        (rst_n),
        .ack_i        (wbd_ack_i),
        .err_i        (wbd_err_i),
        .rdata_i      (wbd_dat_i),
        .head_width_i (head.width),
        .head_offs_i  (head.addr[`DMEM_WB_OFFS_WIDTH-1:0]),
        .rdata_o      (dmem_rdata_o),
        .resp_o       (dmem_resp_o)
    );

endmodule

`default_nettype wire

/* tests/tb_clk_gen.sv */
// Testbench clock and synchronous reset generator
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    // Free running clock, low at time zero
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset held low for the first rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

/* tests/tb_dmem_wb.sv */
// Testbench top with stimulus reader, core driver, slave model, queue model, checks and timeout
`timescale 1ns/10ps
`default_nettype none

`include "dmem_wb_macros.svh"

module tb_dmem_wb
    import dmem_wb_pkg::*;
;

    // ------------------------------------------------------------------------
    // Stimulus layout of one transaction line
    // ------------------------------------------------------------------------

    localparam int N_LINES     = 20;
    localparam int N_FIELDS    = 12;
    localparam int F_IDLE      = 0;
    localparam int F_CMD       = 1;
    localparam int F_WIDTH     = 2;
    localparam int F_ADDR      = 3;
    localparam int F_WDATA     = 4;
    localparam int F_WAIT      = 5;
    localparam int F_ERR       = 6;
    localparam int F_SRDATA    = 7;
    localparam int F_EXP_DAT   = 8;
    localparam int F_EXP_SEL   = 9;
    localparam int F_EXP_RDATA = 10;
    localparam int F_EXP_RESP  = 11;
    // Run length limit in clock cycles
    localparam int CYCLE_LIMIT = 40 * N_LINES + 20;

    logic        clk;
    logic        rst_n;
    logic [31:0] stim [N_LINES * N_FIELDS];

    // Core side
    logic       dmem_req_i;
    mem_cmd_e   dmem_cmd_i;
    mem_width_e dmem_width_i;
    wb_word_t   dmem_addr_i;
    wb_word_t   dmem_wdata_i;
    logic       dmem_req_ack_o;
    wb_word_t   dmem_rdata_o;
    mem_resp_e  dmem_resp_o;
    // Wishbone side
    logic       wbd_stb_o;
    wb_word_t   wbd_adr_o;
    logic       wbd_we_o;
    wb_word_t   wbd_dat_o;
    wb_sel_t    wbd_sel_o;
    wb_word_t   wbd_dat_i;
    logic       wbd_ack_i;
    logic       wbd_err_i;

    // Expected queue occupancy and bookkeeping
    int model_cnt;
    int ack_count;
    int resp_count;
    int stall_cycles;
    int cycle_cnt;

    tb_clk_gen #(
        .PERIOD_NS  (100),
        .RST_CYCLES (4)
    ) i_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    dmem_wb_bridge i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .dmem_req_i     (dmem_req_i),
        .dmem_cmd_i     (dmem_cmd_i),
        .dmem_width_i   (dmem_width_i),
        .dmem_addr_i    (dmem_addr_i),
        .dmem_wdata_i   (dmem_wdata_i),
        .dmem_req_ack_o (dmem_req_ack_o),
        .dmem_rdata_o   (dmem_rdata_o),
        .dmem_resp_o    (dmem_resp_o),
        .wbd_stb_o      (wbd_stb_o),
        .wbd_adr_o      (wbd_adr_o),
        .wbd_we_o       (wbd_we_o),
        .wbd_dat_o      (wbd_dat_o),
        .wbd_sel_o      (wbd_sel_o),
        .wbd_dat_i      (wbd_dat_i),
        .wbd_ack_i      (wbd_ack_i),
        .wbd_err_i      (wbd_err_i)
    );

    // ------------------------------------------------------------------------
    // Helpers and compare tasks
    // ------------------------------------------------------------------------

    function automatic logic [31:0] stim_field(input int line, input int col);
        return stim[line * N_FIELDS + col];
    endfunction

    task automatic stop_on_failure();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input wb_word_t act, input wb_word_t exp);
        if (act !== exp) begin
            $display("ERR %s exp=%h act=%h", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_sel(input string name, input wb_sel_t act, input wb_sel_t exp);
        if (act !== exp) begin
            $display("ERR %s exp=%h act=%h", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_resp(input string name, input mem_resp_e act, input mem_resp_e exp);
        if (act !== exp) begin
            $display("ERR %s exp=%h act=%h", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("ERR %s exp=%h act=%h", name, exp, act);
            stop_on_failure();
        end
    endtask

    // ------------------------------------------------------------------------
    // Queue model and timeout on the rising edge
    // ------------------------------------------------------------------------

    always @(posedge clk) begin
        if (!rst_n) begin
            model_cnt <= 0;
        end else begin
            // Push only with room and pop only with an entry
            model_cnt <= model_cnt
                       + ((dmem_req_i && model_cnt < `DMEM_REQ_FIFO_DEPTH) ? 1 : 0)
                       - ((wbd_ack_i && model_cnt > 0) ? 1 : 0);
        end
    end

    initial begin
        cycle_cnt = 0;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, transactions did not complete", cycle_cnt);
            stop_on_failure();
        end
    end

    // ------------------------------------------------------------------------
    // Wishbone slave model and response checker on the falling edge
    // ------------------------------------------------------------------------

    initial begin : slave_model
        int          wait_cnt;
        int          ack_line;
        logic [31:0] f;
        mem_resp_e   exp_resp;
        wbd_ack_i  = 1'b0;
        wbd_err_i  = 1'b0;
        wbd_dat_i  = '0;
        wait_cnt   = 0;
        ack_line   = 0;
        ack_count  = 0;
        resp_count = 0;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                // Handshake flags follow the occupancy
                check_flag("dmem_req_ack_o", dmem_req_ack_o, model_cnt < `DMEM_REQ_FIFO_DEPTH);
                check_flag("wbd_stb_o", wbd_stb_o, model_cnt != 0);
                // Response pulses counted in every cycle
                if (dmem_resp_o != MEM_RESP_NOTRDY) begin
                    resp_count++;
                end
                if (wbd_ack_i) begin
                    // Completion taken on the last rising edge
                    f = stim_field(ack_line, F_EXP_RESP);
                    exp_resp = mem_resp_e'(f[1:0]);
                    check_resp("dmem_resp_o", dmem_resp_o, exp_resp);
                    f = stim_field(ack_line, F_CMD);
                    if (f[0] == 1'b0) begin
                        check_word("dmem_rdata_o", dmem_rdata_o,
                                   stim_field(ack_line, F_EXP_RDATA));
                    end
                    wbd_ack_i = 1'b0;
                    wbd_err_i = 1'b0;
                    wbd_dat_i = '0;
                end else begin
                    check_resp("dmem_resp_o", dmem_resp_o, MEM_RESP_NOTRDY);
                end
                if (wbd_stb_o) begin
                    if (ack_count >= N_LINES) begin
                        $display("Wishbone strobe raised with no request left to serve");
                        stop_on_failure();
                    end
                    // Requests retire in file order
                    if (wait_cnt >= int'(stim_field(ack_count, F_WAIT))) begin
                        ack_line = ack_count;
                        check_word("wbd_adr_o", wbd_adr_o, stim_field(ack_line, F_ADDR));
                        f = stim_field(ack_line, F_CMD);
                        check_flag("wbd_we_o", wbd_we_o, f[0]);
                        if (f[0]) begin
                            check_word("wbd_dat_o", wbd_dat_o, stim_field(ack_line, F_EXP_DAT));
                        end
                        f = stim_field(ack_line, F_EXP_SEL);
                        check_sel("wbd_sel_o", wbd_sel_o, f[3:0]);
                        f = stim_field(ack_line, F_ERR);
                        wbd_err_i = f[0];
                        wbd_dat_i = stim_field(ack_line, F_SRDATA);
                        wbd_ack_i = 1'b1;
                        ack_count++;
                        wait_cnt = 0;
                    end else begin
                        wait_cnt++;
                    end
                end
            end else begin
                wait_cnt = 0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Core request driver and end of run
    // ------------------------------------------------------------------------

    initial begin : core_driver
        int          idle;
        logic [31:0] f;
        dmem_req_i   = 1'b0;
        dmem_cmd_i   = MEM_CMD_RD;
        dmem_width_i = MEM_WIDTH_BYTE;
        dmem_addr_i  = '0;
        dmem_wdata_i = '0;
        stall_cycles = 0;
        $readmemh("tests/dmem_wb_stimulus.txt", stim);
        for (int i = 0; i < N_LINES * N_FIELDS; i++) begin
            if ($isunknown(stim[i])) begin
                $display("Stimulus file is missing entries");
                stop_on_failure();
            end
        end
        wait (rst_n === 1'b1);
        @(negedge clk);
        for (int n = 0; n < N_LINES; n++) begin
            idle = int'(stim_field(n, F_IDLE));
            if (idle > 0) begin
                dmem_req_i = 1'b0;
                repeat (idle) @(negedge clk);
            end
            f = stim_field(n, F_CMD);
            dmem_cmd_i = mem_cmd_e'(f[0]);
            f = stim_field(n, F_WIDTH);
            dmem_width_i = mem_width_e'(f[1:0]);
            dmem_addr_i  = stim_field(n, F_ADDR);
            dmem_wdata_i = stim_field(n, F_WDATA);
            dmem_req_i   = 1'b1;
            // Hold until the queue has room
            while (!dmem_req_ack_o) begin
                stall_cycles++;
                @(negedge clk);
            end
            // Accepted on the rising edge in between
            @(negedge clk);
        end
        dmem_req_i = 1'b0;
        while (ack_count < N_LINES) @(posedge clk);
        // Idle cycles for the last response and any stray one
        repeat (3) @(posedge clk);
        if (resp_count == ack_count && stall_cycles > 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("Responses do not match acknowledges or the queue never filled");
            stop_on_failure();
        end
    end

endmodule

`default_nettype wire

/* tests/dmem_wb_stimulus.txt */
// idle cmd width addr wdata wait err slave_rdata exp_wbd_dat exp_sel exp_rdata exp_resp
// cmd 0 read 1 write, width 0 byte 1 halfword 2 word, resp 1 ready-OK 2 ready-error
// Byte writes at every offset
3 1 0 00001000 a1b2c3d4 00 0 00000000 000000d4 1 00000000 1
0 1 0 00001001 11223344 00 0 00000000 00004400 2 00000000 1
0 1 0 00001002 55667788 01 0 00000000 00880000 4 00000000 1
0 1 0 00001003 99aabbcc 00 0 00000000 cc000000 8 00000000 1
// Halfword and word writes
0 1 1 00002000 deadbeef 00 0 00000000 0000beef 3 00000000 1
0 1 1 00002002 cafef00d 02 0 00000000 f00d0000 c 00000000 1
0 1 2 00003000 12345678 00 0 00000000 12345678 f 00000000 1
// Byte reads at every offset
1 0 0 00004000 00000000 00 0 8899aabb 00000000 1 000000bb 1
0 0 0 00004001 00000000 01 0 8899aabb 00000000 2 000000aa 1
0 0 0 00004002 00000000 00 0 8899aabb 00000000 4 00000099 1
0 0 0 00004003 00000000 00 0 8899aabb 00000000 8 00000088 1
// Halfword and word reads
0 0 1 00005000 00000000 00 0 f1e2d3c4 00000000 3 0000d3c4 1
0 0 1 00005002 00000000 02 0 f1e2d3c4 00000000 c 0000f1e2 1
0 0 2 00006000 00000000 03 0 0badcafe 00000000 f 0badcafe 1
// Slave error on a read and on a write
2 0 2 00007000 00000000 00 1 13572468 00000000 f 13572468 2
0 1 0 00007005 000000ee 01 1 00000000 0000ee00 2 00000000 2
// Slow first transfer, three requests back to back
4 1 2 00008000 01020304 08 0 00000000 01020304 f 00000000 1
0 0 1 00008002 00000000 00 0 5a5b5c5d 00000000 c 00005a5b 1
0 1 0 00008003 000000ff 01 0 00000000 ff000000 8 00000000 1
// Read error with alignment
1 0 0 00009001 00000000 00 1 00003c00 00000000 2 0000003c 2

/* verilog.f */
+incdir+common
common/dmem_wb_pkg.sv
hw/req_path/dmem_req_pack.sv
hw/req_path/dmem_req_fifo.sv
hw/dmem_resp_align.sv
hw/dmem_wb_bridge.sv
tests/tb_clk_gen.sv
tests/tb_dmem_wb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary -f verilog.f --top-module tb_dmem_wb -Mdir obj_dir -o tb_dmem_wb \
    > build.log 2>&1 || { cat build.log; echo "BUILD FAILED"; exit 1; }

./obj_dir/tb_dmem_wb > sim.log 2>&1
cat sim.log

grep -q "sim failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
